// File: verilog/seq_format_pkg.sv
package seq_format_pkg;

    // Nucleotide code, A=0 C=1 G=2 T=3
    typedef logic [1:0] base_t;

    // Phred scaled base quality
    typedef logic [7:0] quality_t;

    localparam int WORD_WIDTH     = 32;
    localparam int BASES_PER_WORD = WORD_WIDTH / $bits(base_t);
    localparam int QUALS_PER_WORD = WORD_WIDTH / $bits(quality_t);

    // Target memory of a stream word
    typedef enum logic [1:0] {
        STORE_R,
        STORE_Q,
        STORE_H
    } store_type_t;

    // One stream word, seen as bases or as qualities
    // Element 0 sits in the low bits of the word
    typedef union packed {
        base_t    [BASES_PER_WORD-1:0] bases;
        quality_t [QUALS_PER_WORD-1:0] quals;
    } stream_word_u;

endpackage

// File: verilog/worker_ctrl_pkg.sv
package worker_ctrl_pkg;

    // Tag returned with the result of a request
    typedef logic [7:0] req_id_t;

    // Scan engine states
    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DRAIN
    } scan_state_t;

    // Score holds up to max_len qualities of 8 bits each
    function automatic int score_width(input int max_len);
        return 8 + $clog2(max_len);
    endfunction

endpackage

// File: verilog/seq_mem_if.sv
`timescale 1ns/10ps

interface seq_mem_if #(
    parameter int ADDR_WIDTH = 9
);

    // Write port, filled from the stream
    logic                                  write_en;
    logic [ADDR_WIDTH-1:0]                 write_addr;
    logic [seq_format_pkg::WORD_WIDTH-1:0] write_data;

    // Read port, data comes back one cycle after read_en
    logic                                  read_en;
    logic [ADDR_WIDTH-1:0]                 read_addr;
    logic [seq_format_pkg::WORD_WIDTH-1:0] read_data;

    modport writer (output write_en, write_addr, write_data);

    modport reader (output read_en, read_addr, input read_data);

    modport memory (
        input  write_en, write_addr, write_data, read_en, read_addr,
        output read_data
    );

endinterface

// File: verilog/seq_word_ram.sv
`timescale 1ns/10ps

module seq_word_ram #(
    parameter int MAX_SEQUENCE_LENGTH = 2048
) (
    input logic       clock_i,
    seq_mem_if.memory mem
);

    // Four qualities per word is the densest type, so it sets the depth
    localparam int DEPTH = MAX_SEQUENCE_LENGTH / 4;

    logic [seq_format_pkg::WORD_WIDTH-1:0] words [DEPTH];

    always_ff @(posedge clock_i) begin
        if (mem.write_en) begin
            words[mem.write_addr] <= mem.write_data;
        end
    end

    // Registered read port
    always_ff @(posedge clock_i) begin
        if (mem.read_en) begin
            mem.read_data <= words[mem.read_addr];
        end
    end

endmodule

// File: verilog/stream_store_decode.sv
`timescale 1ns/10ps

module stream_store_decode #(
    parameter int MAX_SEQUENCE_LENGTH = 2048
) (
    input  logic                                  clock_i,
    input  logic                                  reset_i,
    input  logic                                  stream_valid_i,
    input  logic [seq_format_pkg::WORD_WIDTH-1:0] stream_data_i,
    input  seq_format_pkg::store_type_t           stream_type_i,
    seq_mem_if.writer                             read_base_mem,
    seq_mem_if.writer                             read_qual_mem,
    seq_mem_if.writer                             hap_base_mem
);

    localparam int ADDR_W = $clog2(MAX_SEQUENCE_LENGTH / 4);

    logic                                  valid_q;
    logic [seq_format_pkg::WORD_WIDTH-1:0] data_q;
    seq_format_pkg::store_type_t           type_q;
    logic [ADDR_W-1:0]                     word_count_q;

    // Input stage, the stream is never back-pressured
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            type_q  <= seq_format_pkg::STORE_R;
        end else begin
            valid_q <= stream_valid_i;
            type_q  <= stream_type_i;
        end
    end

    always_ff @(posedge clock_i) begin
        data_q <= stream_data_i;
    end

    // Word counter restarts with every new type run
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            word_count_q <= '0;
        end else if (stream_type_i != type_q) begin
            word_count_q <= '0;
        end else if (valid_q) begin
            word_count_q <= word_count_q + 1'b1;
        end
    end

    // Shared write path, the enable picks the memory
    assign read_base_mem.write_data = data_q;
    assign read_qual_mem.write_data = data_q;
    assign hap_base_mem.write_data  = data_q;

    assign read_base_mem.write_addr = word_count_q;
    assign read_qual_mem.write_addr = word_count_q;
    assign hap_base_mem.write_addr  = word_count_q;

    assign read_base_mem.write_en = valid_q && (type_q == seq_format_pkg::STORE_R);
    assign read_qual_mem.write_en = valid_q && (type_q == seq_format_pkg::STORE_Q);
    assign hap_base_mem.write_en  = valid_q && (type_q == seq_format_pkg::STORE_H);

endmodule

// File: verilog/mismatch_scan_execute.sv
`timescale 1ns/10ps

module mismatch_scan_execute #(
    parameter int MAX_SEQUENCE_LENGTH = 2048
) (
    input  logic                                   clock_i,
    input  logic                                   reset_i,
    input  logic                                   start_i,
    input  worker_ctrl_pkg::req_id_t               req_id_i,
    input  logic [$clog2(MAX_SEQUENCE_LENGTH)-1:0] req_len_min_1_i,
    output logic                                   ready_o,
    input  logic                                   result_taken_i,
    seq_mem_if.reader                              read_base_mem,
    seq_mem_if.reader                              read_qual_mem,
    seq_mem_if.reader                              hap_base_mem,
    output logic                                   finish_o,
    output logic [worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH)-1:0] score_o,
    output worker_ctrl_pkg::req_id_t               id_o
);

    localparam int LEN_W      = $clog2(MAX_SEQUENCE_LENGTH);
    localparam int ADDR_W     = $clog2(MAX_SEQUENCE_LENGTH / 4);
    localparam int BASE_SEL_W = $clog2(seq_format_pkg::BASES_PER_WORD);
    localparam int QUAL_SEL_W = $clog2(seq_format_pkg::QUALS_PER_WORD);
    localparam int SCORE_W    = worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH);

    worker_ctrl_pkg::scan_state_t state_q, state_d;
    worker_ctrl_pkg::req_id_t     id_q;
    logic [LEN_W-1:0]             len_q;
    logic [LEN_W-1:0]             pos_q;
    logic                         start_accept;
    logic                         issue;
    logic                         last_issue;

    logic [BASE_SEL_W-1:0] base_sel_q;
    logic [QUAL_SEL_W-1:0] qual_sel_q;
    logic                  rd_valid_q;
    logic                  rd_last_q;
    logic                  acc_last_q;
    logic                  finish_q;
    logic [SCORE_W-1:0]    score_q;

    seq_format_pkg::stream_word_u read_word;
    seq_format_pkg::stream_word_u qual_word;
    seq_format_pkg::stream_word_u hap_word;
    seq_format_pkg::base_t        read_base;
    seq_format_pkg::base_t        hap_base;
    seq_format_pkg::quality_t     base_qual;

    ////////////////////
    // Control
    ////////////////////

    assign ready_o      = (state_q == worker_ctrl_pkg::IDLE);
    assign start_accept = start_i && ready_o;
    assign issue        = (state_q == worker_ctrl_pkg::SCAN);
    assign last_issue   = issue && (pos_q == len_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            worker_ctrl_pkg::IDLE: begin
                if (start_i) begin
                    state_d = worker_ctrl_pkg::SCAN;
                end
            end
            worker_ctrl_pkg::SCAN: begin
                if (last_issue) begin
                    state_d = worker_ctrl_pkg::DRAIN;
                end
            end
            // Wait here until the result stage hands the score over
            worker_ctrl_pkg::DRAIN: begin
                if (result_taken_i) begin
                    state_d = worker_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_d = worker_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q    <= worker_ctrl_pkg::IDLE;
            pos_q      <= '0;
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
            acc_last_q <= 1'b0;
            finish_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start_accept) begin
                pos_q <= '0;
            end else if (issue) begin
                pos_q <= pos_q + 1'b1;
            end
            // Last flag travels with the data, one stage past the final add
            rd_valid_q <= issue;
            rd_last_q  <= last_issue;
            acc_last_q <= rd_last_q;
            finish_q   <= acc_last_q;
        end
    end

    // Request latch
    always_ff @(posedge clock_i) begin
        if (start_accept) begin
            id_q  <= req_id_i;
            len_q <= req_len_min_1_i;
        end
    end

    ////////////////////
    // Memory reads
    ////////////////////

    assign read_base_mem.read_en = issue;
    assign read_qual_mem.read_en = issue;
    assign hap_base_mem.read_en  = issue;

    assign read_base_mem.read_addr = ADDR_W'(pos_q[LEN_W-1:BASE_SEL_W]);
    assign hap_base_mem.read_addr  = ADDR_W'(pos_q[LEN_W-1:BASE_SEL_W]);
    assign read_qual_mem.read_addr = pos_q[LEN_W-1:QUAL_SEL_W];

    // Selects line up with the word returned next cycle
    always_ff @(posedge clock_i) begin
        if (issue) begin
            base_sel_q <= pos_q[BASE_SEL_W-1:0];
            qual_sel_q <= pos_q[QUAL_SEL_W-1:0];
        end
    end

    assign read_word = read_base_mem.read_data;
    assign qual_word = read_qual_mem.read_data;
    assign hap_word  = hap_base_mem.read_data;

    assign read_base = read_word.bases[base_sel_q];
    assign hap_base  = hap_word.bases[base_sel_q];
    assign base_qual = qual_word.quals[qual_sel_q];

    ////////////////////
    // Accumulate
    ////////////////////

    always_ff @(posedge clock_i) begin
        if (start_accept) begin
            score_q <= '0;
        end else if (rd_valid_q && (read_base != hap_base)) begin
            score_q <= score_q + SCORE_W'(base_qual);
        end
    end

    assign finish_o = finish_q;
    assign score_o  = score_q;
    assign id_o     = id_q;

endmodule

// File: verilog/score_result.sv
`timescale 1ns/10ps

module score_result #(
    parameter int MAX_SEQUENCE_LENGTH = 2048
) (
    input  logic                                clock_i,
    input  logic                                reset_i,
    input  logic                                finish_i,
    input  logic [worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH)-1:0] score_i,
    input  worker_ctrl_pkg::req_id_t            id_i,
    input  logic                                result_ready_i,
    output logic                                result_valid_o,
    output logic [worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH)-1:0] result_score_o,
    output worker_ctrl_pkg::req_id_t            result_id_o,
    output logic                                done_o,
    output logic                                result_taken_o
);

    localparam int SCORE_W = worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH);

    logic                     valid_q;
    logic [SCORE_W-1:0]       score_q;
    worker_ctrl_pkg::req_id_t id_q;
    logic                     transfer;

    assign transfer = valid_q && result_ready_i;

    // Valid holds until the consumer takes the result
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (finish_i) begin
            valid_q <= 1'b1;
        end else if (transfer) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock_i) begin
        if (finish_i) begin
            score_q <= score_i;
            id_q    <= id_i;
        end
    end

    assign result_valid_o = valid_q;
    assign result_score_o = score_q;
    assign result_id_o    = id_q;

    // Same cycle as the handshake
    assign done_o         = transfer;
    assign result_taken_o = transfer;

endmodule

// File: verilog/pairhmm_worker_top.sv
`timescale 1ns/10ps

module pairhmm_worker_top #(
    parameter int MAX_SEQUENCE_LENGTH = 2048
) (
    input  logic                                   clock_i,
    input  logic                                   reset_i,
    input  logic                                   stream_valid_i,
    input  logic [seq_format_pkg::WORD_WIDTH-1:0]  stream_data_i,
    input  seq_format_pkg::store_type_t            stream_type_i,
    input  logic                                   start_i,
    input  worker_ctrl_pkg::req_id_t               req_id_i,
    input  logic [$clog2(MAX_SEQUENCE_LENGTH)-1:0] req_len_min_1_i,
    output logic                                   ready_o,
    output logic                                   result_valid_o,
    input  logic                                   result_ready_i,
    output logic [worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH)-1:0] result_score_o,
    output worker_ctrl_pkg::req_id_t               result_id_o,
    output logic                                   done_o
);

    localparam int ADDR_W  = $clog2(MAX_SEQUENCE_LENGTH / 4);
    localparam int SCORE_W = worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH);

    logic                     finish;
    logic [SCORE_W-1:0]       score;
    worker_ctrl_pkg::req_id_t id;
    logic                     result_taken;

    seq_mem_if #(.ADDR_WIDTH(ADDR_W)) read_base_bus ();
    seq_mem_if #(.ADDR_WIDTH(ADDR_W)) read_qual_bus ();
    seq_mem_if #(.ADDR_WIDTH(ADDR_W)) hap_base_bus ();

    ////////////////////
    // Decode
    ////////////////////

    stream_store_decode #(
        .MAX_SEQUENCE_LENGTH(MAX_SEQUENCE_LENGTH)
    ) decode_i (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .stream_valid_i(stream_valid_i),
        .stream_data_i (stream_data_i),
        .stream_type_i (stream_type_i),
        .read_base_mem (read_base_bus),
        .read_qual_mem (read_qual_bus),
        .hap_base_mem  (hap_base_bus)
    );

    seq_word_ram #(.MAX_SEQUENCE_LENGTH(MAX_SEQUENCE_LENGTH)) read_base_ram_i (
        .clock_i(clock_i),
        .mem    (read_base_bus)
    );

    seq_word_ram #(.MAX_SEQUENCE_LENGTH(MAX_SEQUENCE_LENGTH)) read_qual_ram_i (
        .clock_i(clock_i),
        .mem    (read_qual_bus)
    );

    seq_word_ram #(.MAX_SEQUENCE_LENGTH(MAX_SEQUENCE_LENGTH)) hap_base_ram_i (
        .clock_i(clock_i),
        .mem    (hap_base_bus)
    );

    ////////////////////
    // Execute and result
    ////////////////////

    mismatch_scan_execute #(
        .MAX_SEQUENCE_LENGTH(MAX_SEQUENCE_LENGTH)
    ) execute_i (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .start_i        (start_i),
        .req_id_i       (req_id_i),
        .req_len_min_1_i(req_len_min_1_i),
        .ready_o        (ready_o),
        .result_taken_i (result_taken),
        .read_base_mem  (read_base_bus),
        .read_qual_mem  (read_qual_bus),
        .hap_base_mem   (hap_base_bus),
        .finish_o       (finish),
        .score_o        (score),
        .id_o           (id)
    );

    score_result #(
        .MAX_SEQUENCE_LENGTH(MAX_SEQUENCE_LENGTH)
    ) result_i (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .finish_i      (finish),
        .score_i       (score),
        .id_i          (id),
        .result_ready_i(result_ready_i),
        .result_valid_o(result_valid_o),
        .result_score_o(result_score_o),
        .result_id_o   (result_id_o),
        .done_o        (done_o),
        .result_taken_o(result_taken)
    );

endmodule

// File: tests/worker_assertions.sv
`timescale 1ns/10ps

module worker_assertions #(
    parameter int SCORE_W = 16
) (
    input logic               clock_i,
    input logic               reset_i,
    input logic               ready_i,
    input logic               result_valid_i,
    input logic               result_ready_i,
    input logic [SCORE_W-1:0] result_score_i,
    input logic [7:0]         result_id_i,
    input logic               done_i
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // done_o only in the transfer cycle
    done_needs_handshake: assert property (@(posedge clock_i) disable iff (reset_i)
        done_i |-> (result_valid_i && result_ready_i))
    else begin
        fail_count++;
        $error("done_o high without a result transfer");
    end

    handshake_gives_done: assert property (@(posedge clock_i) disable iff (reset_i)
        (result_valid_i && result_ready_i) |-> done_i)
    else begin
        fail_count++;
        $error("Result transfer without a done_o pulse");
    end

    // Waiting result must not move
    result_held_stable: assert property (@(posedge clock_i) disable iff (reset_i)
        (result_valid_i && !result_ready_i) |=>
            (result_valid_i && $stable(result_score_i) && $stable(result_id_i)))
    else begin
        fail_count++;
        $error("Result changed or dropped before the transfer");
    end

    no_start_while_pending: assert property (@(posedge clock_i) disable iff (reset_i)
        result_valid_i |-> !ready_i)
    else begin
        fail_count++;
        $error("ready_o high while a result is pending");
    end

endmodule

// File: tests/worker_checker.sv
`timescale 1ns/10ps

module worker_checker #(
    parameter int MAX_SEQUENCE_LENGTH = 256
) (
    input  logic                                   clock_i,
    input  logic                                   reset_i,
    input  logic                                   stream_valid_i,
    input  logic [31:0]                            stream_data_i,
    input  seq_format_pkg::store_type_t            stream_type_i,
    input  logic                                   start_i,
    input  logic                                   ready_i,
    input  worker_ctrl_pkg::req_id_t               req_id_i,
    input  logic [$clog2(MAX_SEQUENCE_LENGTH)-1:0] req_len_min_1_i,
    input  logic                                   result_valid_i,
    input  logic                                   result_ready_i,
    input  logic [worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH)-1:0] result_score_i,
    input  worker_ctrl_pkg::req_id_t               result_id_i,
    input  logic                                   done_i,
    input  logic [8*16-1:0]                        test_name_i,
    output int                                     error_count_o,
    output int                                     result_count_o,
    output int                                     pending_count_o
);

    localparam int DEPTH  = MAX_SEQUENCE_LENGTH / 4;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int SCORE_W = worker_ctrl_pkg::score_width(MAX_SEQUENCE_LENGTH);

    // One model memory per stream type
    logic [31:0] read_words [DEPTH];
    logic [31:0] qual_words [DEPTH];
    logic [31:0] hap_words  [DEPTH];

    seq_format_pkg::store_type_t last_type;
    logic [ADDR_W-1:0]           word_addr;

    int unsigned              exp_score_q [$];
    worker_ctrl_pkg::req_id_t exp_id_q [$];
    string                    name_q [$];

    int                       errors = 0;
    int                       results = 0;
    int                       pending = 0;
    logic                     hold_pending = 1'b0;
    logic [SCORE_W-1:0]       hold_score;
    worker_ctrl_pkg::req_id_t hold_id;

    assign error_count_o   = errors;
    assign result_count_o  = results;
    assign pending_count_o = pending;

    // Sum of qualities where read and haplotype bases differ
    function automatic int unsigned mismatch_score(input int len);
        int unsigned       sum;
        logic [ADDR_W-1:0] base_addr;
        logic [ADDR_W-1:0] qual_addr;
        logic [3:0]        base_sel;
        logic [1:0]        qual_sel;
        logic [1:0]        read_base;
        logic [1:0]        hap_base;
        logic [7:0]        qual;
        sum = 0;
        for (int p = 0; p < len; p++) begin
            base_addr = ADDR_W'(p / 16);
            base_sel  = 4'(p % 16);
            qual_addr = ADDR_W'(p / 4);
            qual_sel  = 2'(p % 4);
            read_base = read_words[base_addr][{base_sel, 1'b0} +: 2];
            hap_base  = hap_words[base_addr][{base_sel, 1'b0} +: 2];
            qual      = qual_words[qual_addr][{qual_sel, 3'b000} +: 8];
            if (read_base != hap_base) begin
                sum += int'(qual);
            end
        end
        return sum;
    endfunction

    always @(posedge clock_i) begin
        int unsigned              exp_score;
        worker_ctrl_pkg::req_id_t exp_id;
        string                    name;
        if (reset_i) begin
            last_type    = seq_format_pkg::STORE_R;
            word_addr    = '0;
            hold_pending = 1'b0;
        end else begin
            ////////////////////
            // Stream mirror
            ////////////////////
            if (stream_type_i != last_type) begin
                word_addr = '0;
            end
            if (stream_valid_i) begin
                case (stream_type_i)
                    seq_format_pkg::STORE_R: read_words[word_addr] = stream_data_i;
                    seq_format_pkg::STORE_Q: qual_words[word_addr] = stream_data_i;
                    seq_format_pkg::STORE_H: hap_words[word_addr] = stream_data_i;
                    default: ;
                endcase
                word_addr = word_addr + 1'b1;
            end
            last_type = stream_type_i;

            // Accepted start
            if (start_i && ready_i) begin
                exp_score_q.push_back(mismatch_score(int'(req_len_min_1_i) + 1));
                exp_id_q.push_back(req_id_i);
                name_q.push_back(string'(test_name_i));
                pending++;
            end

            ////////////////////
            // Result compare
            ////////////////////
            if (result_valid_i && result_ready_i) begin
                results++;
                if (exp_score_q.size() == 0) begin
                    errors++;
                    $display("Result with id %0d arrived while no request was pending",
                             result_id_i);
                end else begin
                    exp_score = exp_score_q.pop_front();
                    exp_id    = exp_id_q.pop_front();
                    name      = name_q.pop_front();
                    pending--;
                    if (result_score_i !== SCORE_W'(exp_score)) begin
                        errors++;
                        $display("[ERROR] %s: score expected %0d, actual %0d",
                                 name, exp_score, result_score_i);
                    end
                    if (result_id_i !== exp_id) begin
                        errors++;
                        $display("[ERROR] %s: id expected %0d, actual %0d",
                                 name, exp_id, result_id_i);
                    end
                end
            end

            if (done_i != (result_valid_i && result_ready_i)) begin
                errors++;
                $display("done_o is %0b but the result transfer is %0b", done_i,
                         result_valid_i && result_ready_i);
            end
            if (result_valid_i && ready_i) begin
                errors++;
                $display("ready_o is high while a result is waiting");
            end
            if (hold_pending) begin
                if (!result_valid_i) begin
                    errors++;
                    $display("result_valid_o dropped before the transfer");
                end else if (result_score_i !== hold_score || result_id_i !== hold_id) begin
                    errors++;
                    $display("Result score or id changed while waiting for result_ready_i");
                end
            end
            hold_pending = result_valid_i && !result_ready_i;
            hold_score   = result_score_i;
            hold_id      = result_id_i;
        end
    end

endmodule

// File: tests/worker_tb.sv
`timescale 1ns/10ps

module worker_tb;

    localparam int MAX_LEN     = 256;
    localparam int LEN_W       = $clog2(MAX_LEN);
    localparam int SCORE_W     = worker_ctrl_pkg::score_width(MAX_LEN);
    localparam int NUM_RESULTS = 6;

    // Stream words of all runs and lengths of all requests
    localparam int STREAM_WORDS   = 24 + 96 + 16;
    localparam int TOTAL_LENGTH   = 64 + 1 + 37 + 256 + 256 + 50;
    localparam int TIMEOUT_CYCLES = (STREAM_WORDS + TOTAL_LENGTH + NUM_RESULTS * 20) * 2;

    logic                        clock = 1'b0;
    logic                        reset;
    logic                        stream_valid;
    logic [31:0]                 stream_data;
    seq_format_pkg::store_type_t stream_type;
    logic                        start;
    worker_ctrl_pkg::req_id_t    req_id;
    logic [LEN_W-1:0]            req_len_min_1;
    logic                        ready;
    logic                        result_valid;
    logic                        result_ready;
    logic [SCORE_W-1:0]          result_score;
    worker_ctrl_pkg::req_id_t    result_id;
    logic                        done;
    logic [8*16-1:0]             test_name;

    integer      seed;
    logic [31:0] word_buf [$];
    int          cycle_count = 0;
    int          checker_errors;
    int          result_count;
    int          pending_count;
    int          other_errors;
    int unsigned assert_fails;

    always #20 clock = ~clock;

    pairhmm_worker_top #(.MAX_SEQUENCE_LENGTH(MAX_LEN)) dut_i (
        .clock_i        (clock),
        .reset_i        (reset),
        .stream_valid_i (stream_valid),
        .stream_data_i  (stream_data),
        .stream_type_i  (stream_type),
        .start_i        (start),
        .req_id_i       (req_id),
        .req_len_min_1_i(req_len_min_1),
        .ready_o        (ready),
        .result_valid_o (result_valid),
        .result_ready_i (result_ready),
        .result_score_o (result_score),
        .result_id_o    (result_id),
        .done_o         (done)
    );

    worker_checker #(.MAX_SEQUENCE_LENGTH(MAX_LEN)) checker_i (
        .clock_i        (clock),
        .reset_i        (reset),
        .stream_valid_i (stream_valid),
        .stream_data_i  (stream_data),
        .stream_type_i  (stream_type),
        .start_i        (start),
        .ready_i        (ready),
        .req_id_i       (req_id),
        .req_len_min_1_i(req_len_min_1),
        .result_valid_i (result_valid),
        .result_ready_i (result_ready),
        .result_score_i (result_score),
        .result_id_i    (result_id),
        .done_i         (done),
        .test_name_i    (test_name),
        .error_count_o  (checker_errors),
        .result_count_o (result_count),
        .pending_count_o(pending_count)
    );

    bind pairhmm_worker_top worker_assertions #(.SCORE_W($bits(result_score_o)))
        handshake_assert_i (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .ready_i       (ready_o),
        .result_valid_i(result_valid_o),
        .result_ready_i(result_ready_i),
        .result_score_i(result_score_o),
        .result_id_i   (result_id_o),
        .done_i        (done_o)
    );

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic fill_random(input int n_words);
        word_buf.delete();
        for (int i = 0; i < n_words; i++) begin
            word_buf.push_back($random(seed));
        end
    endtask

    // Leading cycle with the new type and valid low restarts the counter
    task automatic send_run(input seq_format_pkg::store_type_t kind);
        @(posedge clock);
        stream_type  <= kind;
        stream_valid <= 1'b0;
        for (int i = 0; i < word_buf.size(); i++) begin
            @(posedge clock);
            stream_valid <= 1'b1;
            stream_data  <= word_buf[i];
        end
        @(posedge clock);
        stream_valid <= 1'b0;
    endtask

    task automatic issue_request(input logic [8*16-1:0] name,
                                 input worker_ctrl_pkg::req_id_t id, input int len);
        @(posedge clock);
        while (!ready) begin
            @(posedge clock);
        end
        start         <= 1'b1;
        req_id        <= id;
        req_len_min_1 <= LEN_W'(len - 1);
        test_name     <= name;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic wait_transfer();
        @(posedge clock);
        while (!(result_valid && result_ready)) begin
            @(posedge clock);
        end
    endtask

    task automatic run_request(input logic [8*16-1:0] name,
                               input worker_ctrl_pkg::req_id_t id, input int len);
        issue_request(name, id, len);
        wait_transfer();
    endtask

    // Result held back, with a stray start in the middle of the wait
    task automatic backpressure_request(input logic [8*16-1:0] name,
                                        input worker_ctrl_pkg::req_id_t id, input int len);
        int hold;
        hold = 4 + int'($unsigned($random(seed)) % 28);
        @(posedge clock);
        result_ready <= 1'b0;
        issue_request(name, id, len);
        @(posedge clock);
        while (!result_valid) begin
            @(posedge clock);
        end
        repeat (hold / 2) @(posedge clock);
        start         <= 1'b1;
        req_id        <= id + 8'd1;
        req_len_min_1 <= LEN_W'(len - 1);
        @(posedge clock);
        start <= 1'b0;
        repeat (hold - hold / 2) @(posedge clock);
        result_ready <= 1'b1;
        wait_transfer();
    endtask

    initial begin
        seed          = 32'hbbea_5d74;
        reset         = 1'b1;
        stream_valid  = 1'b0;
        stream_data   = '0;
        stream_type   = seq_format_pkg::STORE_R;
        start         = 1'b0;
        req_id        = '0;
        req_len_min_1 = '0;
        result_ready  = 1'b1;
        test_name     = "reset";
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        // Same bases in read and haplotype
        fill_random(4);
        send_run(seq_format_pkg::STORE_R);
        send_run(seq_format_pkg::STORE_H);
        fill_random(16);
        send_run(seq_format_pkg::STORE_Q);
        run_request("identical_64", 8'h11, 64);

        // Full random memories, short and full lengths
        fill_random(16);
        send_run(seq_format_pkg::STORE_R);
        fill_random(64);
        send_run(seq_format_pkg::STORE_Q);
        fill_random(16);
        send_run(seq_format_pkg::STORE_H);
        run_request("random_1", 8'h21, 1);
        run_request("random_37", 8'h22, 37);
        run_request("random_256", 8'h23, 256);

        // New read bases only
        fill_random(16);
        send_run(seq_format_pkg::STORE_R);
        run_request("rewrite_read", 8'h31, 256);

        backpressure_request("backpressure", 8'h41, 50);
        repeat (4) @(posedge clock);

        other_errors = 0;
        if (result_count != NUM_RESULTS) begin
            other_errors++;
            $display("Expected %0d results but %0d were transferred", NUM_RESULTS,
                     result_count);
        end
        if (pending_count != 0) begin
            other_errors++;
            $display("%0d requests never returned a result", pending_count);
        end
        if (!ready) begin
            other_errors++;
            $display("Engine still busy after the last result, a stray start was taken");
        end
        assert_fails = dut_i.handshake_assert_i.fail_count;
        $display("Error counts: checker %0d, assertions %0d, testbench %0d",
                 checker_errors, assert_fails, other_errors);
        if (checker_errors == 0 && assert_fails == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

// File: compile.f
verilog/seq_format_pkg.sv
verilog/worker_ctrl_pkg.sv
verilog/seq_mem_if.sv
verilog/seq_word_ram.sv
verilog/stream_store_decode.sv
verilog/mismatch_scan_execute.sv
verilog/score_result.sv
verilog/pairhmm_worker_top.sv
tests/worker_assertions.sv
tests/worker_checker.sv
tests/worker_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= worker_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
